// ==== Makefile ====
SIM := obj_dir/Vkernel_wrapper_tb

.PHONY: all run clean

all: run

$(SIM): all.f $(wildcard common/*.sv control/*.sv source/*.sv verif/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module kernel_wrapper_tb -Mdir obj_dir -f all.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
common/kernel_pkg.sv
control/axi_lite_slave.sv
control/kernel_ctrl_reg.sv
control/kernel_param_mem.sv
source/kernel_run_ctrl.sv
source/kernel_wrapper.sv
verif/kernel_wrapper_sva.sv
verif/kernel_wrapper_tb.sv

// ==== common/kernel_pkg.sv ====
// Kernel wrapper package with the register map, bus widths and control word layout.
`default_nettype none

package kernel_pkg;

  // Host control bus widths.
  localparam int addr_width = 12;
  localparam int data_width = 32;
  localparam int strb_width = 4;

  // Parameter store geometry.
  localparam int param_words = 16;
  localparam int param_index_width = 4;

  // Interrupt sources: bit 0 is run done, bit 1 is start taken.
  localparam int irq_width = 2;

  // Control registers sit below ctrl_region_end, parameter words directly above.
  localparam logic [addr_width-1:0] ctrl_region_end = 12'h040;
  localparam logic [addr_width-1:0] param_region_end =
    ctrl_region_end + addr_width'(param_words * strb_width);

  // Control register offsets.
  localparam logic [addr_width-1:0] ctrl_off = 12'h000;
  localparam logic [addr_width-1:0] gie_off  = 12'h004;
  localparam logic [addr_width-1:0] ier_off  = 12'h008;
  localparam logic [addr_width-1:0] isr_off  = 12'h00C;

  // Every access completes with OKAY.
  localparam logic [1:0] resp_okay = 2'b00;

  // Control word, seen either as the raw bus word or as its status fields.
  typedef union packed {
    logic [data_width-1:0] raw;
    struct packed {
      logic [data_width-5:0] reserved;
      logic                  ap_ready;
      logic                  ap_idle;
      logic                  ap_done;
      logic                  ap_start;
    } field;
  } ctrl_word_t;

endpackage

`default_nettype wire

// ==== control/axi_lite_slave.sv ====
// AXI4-Lite slave that serializes host accesses into single-cycle register requests.
`timescale 1ns/1ns
`default_nettype none

module axi_lite_slave (
  input  wire                               ap_clk,
  input  wire                               rst_n,
  input  wire  [kernel_pkg::addr_width-1:0] awaddr,
  input  wire                               awvalid,
  output logic                              awready,
  input  wire  [kernel_pkg::data_width-1:0] wdata,
  input  wire  [kernel_pkg::strb_width-1:0] wstrb,
  input  wire                               wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  wire                               bready,
  input  wire  [kernel_pkg::addr_width-1:0] araddr,
  input  wire                               arvalid,
  output logic                              arready,
  output logic [kernel_pkg::data_width-1:0] rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  wire                               rready,
  output logic                              reg_req,
  output logic                              reg_write_en,
  output logic [kernel_pkg::addr_width-1:0] reg_addr,
  output logic [kernel_pkg::data_width-1:0] reg_wdata,
  output logic [kernel_pkg::strb_width-1:0] reg_wstrb,
  input  wire                               reg_ack,
  input  wire  [kernel_pkg::data_width-1:0] reg_rdata
);

  logic idle;
  logic wr_go;
  logic rd_go;

  // One access in flight, so a pending response blocks new addresses.
  assign idle = !bvalid && !rvalid;

  // Write needs both address and data, and wins over a waiting read.
  assign wr_go = idle && awvalid && wvalid;
  assign rd_go = idle && arvalid && !wr_go;

  assign awready = wr_go;
  assign wready  = wr_go;
  assign arready = rd_go;

  // The register access happens in the handshake cycle.
  assign reg_req      = wr_go || rd_go;
  assign reg_write_en = wr_go;
  assign reg_addr     = wr_go ? awaddr : araddr;
  assign reg_wdata    = wdata;
  assign reg_wstrb    = wstrb;

  // Unmapped accesses still complete cleanly.
  assign bresp = kernel_pkg::resp_okay;
  assign rresp = kernel_pkg::resp_okay;

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
    end else if (wr_go) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_go) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // Read data is captured once and held until the host takes it.
  always_ff @(posedge ap_clk) begin
    if (rd_go) begin
      rdata <= reg_ack ? reg_rdata : '0;
    end
  end

endmodule

`default_nettype wire

// ==== control/kernel_ctrl_reg.sv ====
// Kernel control, interrupt enable and interrupt status registers with interrupt output.
`timescale 1ns/1ns
`default_nettype none

module kernel_ctrl_reg (
  input  wire                               ap_clk,
  input  wire                               rst_n,
  input  wire                               reg_req,
  input  wire                               reg_write_en,
  input  wire  [kernel_pkg::addr_width-1:0] reg_addr,
  input  wire  [kernel_pkg::data_width-1:0] reg_wdata,
  input  wire  [kernel_pkg::strb_width-1:0] reg_wstrb,
  output logic                              reg_ack,
  output logic [kernel_pkg::data_width-1:0] reg_rdata,
  output logic                              go_valid,
  input  wire                               go_holdoff,
  input  wire                               done_event,
  output logic                              interrupt
);

  logic                              hit;
  logic                              wr_hit;
  logic                              rd_hit;
  logic [kernel_pkg::addr_width-1:0] word_addr;
  logic                              ctrl_wr;
  logic                              ctrl_rd;
  logic                              gie_wr;
  logic                              ier_wr;
  logic                              isr_wr;
  logic                              go_fire;
  kernel_pkg::ctrl_word_t            wr_word;
  kernel_pkg::ctrl_word_t            rd_word;
  logic                              ap_start;
  logic                              ap_done;
  logic                              ap_ready;
  logic                              gie;
  logic [kernel_pkg::irq_width-1:0]  ier;
  logic [kernel_pkg::irq_width-1:0]  isr;
  logic [kernel_pkg::irq_width-1:0]  isr_set;
  logic [kernel_pkg::irq_width-1:0]  isr_toggle;

  assign hit       = reg_req && (reg_addr < kernel_pkg::ctrl_region_end);
  assign reg_ack   = hit;
  assign word_addr = {reg_addr[kernel_pkg::addr_width-1:2], 2'b00};

  // All defined bits live in byte lane 0.
  assign wr_hit  = hit && reg_write_en && reg_wstrb[0];
  assign rd_hit  = hit && !reg_write_en;
  assign ctrl_wr = wr_hit && (word_addr == kernel_pkg::ctrl_off);
  assign ctrl_rd = rd_hit && (word_addr == kernel_pkg::ctrl_off);
  assign gie_wr  = wr_hit && (word_addr == kernel_pkg::gie_off);
  assign ier_wr  = wr_hit && (word_addr == kernel_pkg::ier_off);
  assign isr_wr  = wr_hit && (word_addr == kernel_pkg::isr_off);

  // Start is taken when the sequencer is idle.
  assign go_valid = ap_start;
  assign go_fire  = ap_start && !go_holdoff;

  assign isr_set    = {go_fire, done_event};
  assign isr_toggle = isr_wr ? reg_wdata[kernel_pkg::irq_width-1:0] : '0;

  always_comb begin
    wr_word.raw = reg_wdata;
  end

  always_comb begin
    rd_word                = '0;
    rd_word.field.ap_start = ap_start;
    rd_word.field.ap_done  = ap_done;
    rd_word.field.ap_idle  = !go_holdoff;
    rd_word.field.ap_ready = ap_ready;
  end

  always_comb begin
    reg_rdata = '0;
    if (hit) begin
      case (word_addr)
        kernel_pkg::ctrl_off: reg_rdata = rd_word.raw;
        kernel_pkg::gie_off:  reg_rdata = kernel_pkg::data_width'(gie);
        kernel_pkg::ier_off:  reg_rdata = kernel_pkg::data_width'(ier);
        kernel_pkg::isr_off:  reg_rdata = kernel_pkg::data_width'(isr);
        default:              reg_rdata = '0;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      ap_start  <= 1'b0;
      ap_done   <= 1'b0;
      ap_ready  <= 1'b0;
      gie       <= 1'b0;
      ier       <= '0;
      isr       <= '0;
      interrupt <= 1'b0;
    end else begin
      // A host start request beats a same-cycle go acceptance.
      if (go_fire) begin
        ap_start <= 1'b0;
      end
      if (ctrl_wr && wr_word.field.ap_start) begin
        ap_start <= 1'b1;
      end

      // Status flags clear on read, but a new event wins.
      if (ctrl_rd) begin
        ap_done  <= 1'b0;
        ap_ready <= 1'b0;
      end
      if (done_event) begin
        ap_done <= 1'b1;
      end
      if (go_fire) begin
        ap_ready <= 1'b1;
      end

      if (gie_wr) begin
        gie <= reg_wdata[0];
      end
      if (ier_wr) begin
        ier <= reg_wdata[kernel_pkg::irq_width-1:0];
      end
      isr <= (isr ^ isr_toggle) | isr_set;

      interrupt <= gie && |(isr & ier);
    end
  end

endmodule

`default_nettype wire

// ==== control/kernel_param_mem.sv ====
// Kernel parameter store, written by the host and read by the action block.
`timescale 1ns/1ns
`default_nettype none

module kernel_param_mem (
  input  wire                                      ap_clk,
  input  wire                                      rst_n,
  input  wire                                      reg_req,
  input  wire                                      reg_write_en,
  input  wire  [kernel_pkg::addr_width-1:0]        reg_addr,
  input  wire  [kernel_pkg::data_width-1:0]        reg_wdata,
  input  wire  [kernel_pkg::strb_width-1:0]        reg_wstrb,
  output logic                                     reg_ack,
  output logic [kernel_pkg::data_width-1:0]        reg_rdata,
  input  wire                                      param_addr_valid,
  input  wire  [kernel_pkg::param_index_width-1:0] param_addr,
  output logic                                     param_addr_stop,
  output logic                                     param_data_valid,
  output logic [kernel_pkg::data_width-1:0]        param_data,
  input  wire                                      param_data_stop
);

  logic [kernel_pkg::data_width-1:0]        mem [kernel_pkg::param_words];
  logic                                     hit;
  logic [kernel_pkg::param_index_width-1:0] host_index;
  logic                                     addr_accept;

  assign hit = reg_req &&
               (reg_addr >= kernel_pkg::ctrl_region_end) &&
               (reg_addr < kernel_pkg::param_region_end);
  assign reg_ack    = hit;
  assign host_index = reg_addr[kernel_pkg::param_index_width+1:2];

  // Host reads are combinational and independent of the action port.
  assign reg_rdata = hit ? mem[host_index] : '0;

  // Byte strobed host writes.
  always_ff @(posedge ap_clk) begin
    if (hit && reg_write_en) begin
      for (int i = 0; i < kernel_pkg::strb_width; i++) begin
        if (reg_wstrb[i]) begin
          mem[host_index][i*8 +: 8] <= reg_wdata[i*8 +: 8];
        end
      end
    end
  end

  // A new address is only blocked while the held word is stopped.
  assign param_addr_stop = param_data_valid && param_data_stop;
  assign addr_accept     = param_addr_valid && !param_addr_stop;

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      param_data_valid <= 1'b0;
    end else if (!param_addr_stop) begin
      param_data_valid <= param_addr_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (addr_accept) begin
      param_data <= mem[param_addr];
    end
  end

endmodule

`default_nettype wire

// ==== source/kernel_run_ctrl.sv ====
// Run sequencer that releases the action from reset, offers go and waits for done.
`timescale 1ns/1ns
`default_nettype none

module kernel_run_ctrl (
  input  wire  ap_clk,
  input  wire  rst_n,
  input  wire  go_valid,
  output logic go_holdoff,
  output logic go_ready,
  output logic action_rst_n,
  input  wire  go_stop,
  input  wire  done_ready,
  output logic done_stop,
  output logic done_event
);

  // States: idle (reset held), releasing (reset off, no go yet), running.
  logic running;
  logic go_fire;

  assign go_fire = go_ready && !go_stop;

  // Done is only taken once the action has accepted go.
  assign done_stop  = !(running && !go_ready);
  assign done_event = done_ready && !done_stop;

  // Any state other than idle blocks a new start.
  assign go_holdoff = action_rst_n;

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      action_rst_n <= 1'b0;
      running      <= 1'b0;
      go_ready     <= 1'b0;
    end else if (!action_rst_n) begin
      // Idle. A start request lets the action out of reset.
      action_rst_n <= go_valid;
    end else if (!running) begin
      // One cycle out of reset, then offer go.
      running  <= 1'b1;
      go_ready <= 1'b1;
    end else begin
      if (go_fire) begin
        go_ready <= 1'b0;
      end
      // Back into reset after completion.
      if (done_event) begin
        running      <= 1'b0;
        action_rst_n <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/kernel_wrapper.sv ====
// Kernel wrapper top level joining the host slave, registers, parameters and run control.
`timescale 1ns/1ns
`default_nettype none

module kernel_wrapper (
  input  wire                                     ap_clk,
  input  wire                                     rst_n,
  input  wire  [kernel_pkg::addr_width-1:0]        awaddr,
  input  wire                                     awvalid,
  output logic                                    awready,
  input  wire  [kernel_pkg::data_width-1:0]        wdata,
  input  wire  [kernel_pkg::strb_width-1:0]        wstrb,
  input  wire                                     wvalid,
  output logic                                    wready,
  output logic [1:0]                              bresp,
  output logic                                    bvalid,
  input  wire                                     bready,
  input  wire  [kernel_pkg::addr_width-1:0]        araddr,
  input  wire                                     arvalid,
  output logic                                    arready,
  output logic [kernel_pkg::data_width-1:0]        rdata,
  output logic [1:0]                              rresp,
  output logic                                    rvalid,
  input  wire                                     rready,
  output logic                                    interrupt,
  output logic                                    go_ready,
  output logic                                    action_rst_n,
  input  wire                                     go_stop,
  input  wire                                     done_ready,
  output logic                                    done_stop,
  input  wire                                     param_addr_valid,
  input  wire  [kernel_pkg::param_index_width-1:0] param_addr,
  output logic                                    param_addr_stop,
  output logic                                    param_data_valid,
  output logic [kernel_pkg::data_width-1:0]        param_data,
  input  wire                                     param_data_stop
);

  // Register bus from the slave to both targets.
  logic                              reg_req;
  logic                              reg_write_en;
  logic [kernel_pkg::addr_width-1:0] reg_addr;
  logic [kernel_pkg::data_width-1:0] reg_wdata;
  logic [kernel_pkg::strb_width-1:0] reg_wstrb;
  logic                              reg_ack;
  logic [kernel_pkg::data_width-1:0] reg_rdata;
  logic                              ctrl_ack;
  logic [kernel_pkg::data_width-1:0] ctrl_rdata;
  logic                              param_ack;
  logic [kernel_pkg::data_width-1:0] param_rdata;

  // Run handshake between the registers and the sequencer.
  logic go_valid;
  logic go_holdoff;
  logic done_event;

  // Targets only respond inside their own region, so a plain OR merges them.
  assign reg_ack   = ctrl_ack | param_ack;
  assign reg_rdata = ctrl_rdata | param_rdata;

  axi_lite_slave axi_lite_slave_inst (
    .ap_clk(ap_clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .reg_req(reg_req), .reg_write_en(reg_write_en), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .reg_wstrb(reg_wstrb),
    .reg_ack(reg_ack), .reg_rdata(reg_rdata)
  );

  kernel_ctrl_reg kernel_ctrl_reg_inst (
    .ap_clk(ap_clk), .rst_n(rst_n),
    .reg_req(reg_req), .reg_write_en(reg_write_en), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .reg_wstrb(reg_wstrb),
    .reg_ack(ctrl_ack), .reg_rdata(ctrl_rdata),
    .go_valid(go_valid), .go_holdoff(go_holdoff), .done_event(done_event),
    .interrupt(interrupt)
  );

  kernel_param_mem kernel_param_mem_inst (
    .ap_clk(ap_clk), .rst_n(rst_n),
    .reg_req(reg_req), .reg_write_en(reg_write_en), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .reg_wstrb(reg_wstrb),
    .reg_ack(param_ack), .reg_rdata(param_rdata),
    .param_addr_valid(param_addr_valid), .param_addr(param_addr),
    .param_addr_stop(param_addr_stop), .param_data_valid(param_data_valid),
    .param_data(param_data), .param_data_stop(param_data_stop)
  );

  kernel_run_ctrl kernel_run_ctrl_inst (
    .ap_clk(ap_clk), .rst_n(rst_n),
    .go_valid(go_valid), .go_holdoff(go_holdoff),
    .go_ready(go_ready), .action_rst_n(action_rst_n), .go_stop(go_stop),
    .done_ready(done_ready), .done_stop(done_stop), .done_event(done_event)
  );

endmodule

`default_nettype wire

// ==== verif/kernel_wrapper_sva.sv ====
// Kernel wrapper protocol assertions on the AXI4-Lite responses and action handshakes.
`timescale 1ns/1ns
`default_nettype none

module kernel_wrapper_sva (
  input wire                               ap_clk,
  input wire                               rst_n,
  input wire                               bvalid,
  input wire                               bready,
  input wire [1:0]                         bresp,
  input wire                               rvalid,
  input wire                               rready,
  input wire [1:0]                         rresp,
  input wire [kernel_pkg::data_width-1:0]  rdata,
  input wire                               go_ready,
  input wire                               action_rst_n,
  input wire                               param_data_valid,
  input wire                               param_data_stop,
  input wire [kernel_pkg::data_width-1:0]  param_data
);

  // Responses stay valid and unchanged until the host takes them.
  b_hold: assert property (@(posedge ap_clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("write response dropped or changed before bready");

  r_hold: assert property (@(posedge ap_clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("read response dropped or changed before rready");

  go_in_reset: assert property (@(posedge ap_clk) disable iff (!rst_n)
    go_ready |-> action_rst_n)
    else $error("go offered while the action is held in reset");

  param_hold: assert property (@(posedge ap_clk) disable iff (!rst_n)
    param_data_valid && param_data_stop |=> param_data_valid && $stable(param_data))
    else $error("parameter word changed while stopped");

endmodule

bind kernel_wrapper kernel_wrapper_sva kernel_wrapper_sva_inst (
  .ap_clk(ap_clk), .rst_n(rst_n),
  .bvalid(bvalid), .bready(bready), .bresp(bresp),
  .rvalid(rvalid), .rready(rready), .rresp(rresp), .rdata(rdata),
  .go_ready(go_ready), .action_rst_n(action_rst_n),
  .param_data_valid(param_data_valid), .param_data_stop(param_data_stop),
  .param_data(param_data)
);

`default_nettype wire

// ==== verif/kernel_wrapper_tb.sv ====
// Kernel wrapper testbench acting as host and action block, checked against a reference model.
`timescale 1ns/1ns
`default_nettype none

module kernel_wrapper_tb;

  localparam int rand_writes    = 24;
  localparam int unmapped_reads = 4;
  // Fill, random writes and read-back of the parameters, then unmapped, register and run traffic.
  localparam int planned_xfers  = 2 * kernel_pkg::param_words + rand_writes + unmapped_reads + 24;
  localparam int timeout_cycles = 200 * planned_xfers + 2000;
  // The interrupt output trails its sources by one register stage.
  localparam int settle_cycles  = 2;

  logic                                     ap_clk = 1'b0;
  logic                                     rst_n;
  logic [kernel_pkg::addr_width-1:0]        awaddr;
  logic                                     awvalid;
  logic                                     awready;
  logic [kernel_pkg::data_width-1:0]        wdata;
  logic [kernel_pkg::strb_width-1:0]        wstrb;
  logic                                     wvalid;
  logic                                     wready;
  logic [1:0]                               bresp;
  logic                                     bvalid;
  logic                                     bready;
  logic [kernel_pkg::addr_width-1:0]        araddr;
  logic                                     arvalid;
  logic                                     arready;
  logic [kernel_pkg::data_width-1:0]        rdata;
  logic [1:0]                               rresp;
  logic                                     rvalid;
  logic                                     rready;
  logic                                     interrupt;
  logic                                     go_ready;
  logic                                     action_rst_n;
  logic                                     go_stop;
  logic                                     done_ready;
  logic                                     done_stop;
  logic                                     param_addr_valid;
  logic [kernel_pkg::param_index_width-1:0] param_addr;
  logic                                     param_addr_stop;
  logic                                     param_data_valid;
  logic [kernel_pkg::data_width-1:0]        param_data;
  logic                                     param_data_stop;

  integer seed        = 35683;
  int     check_count = 0;
  int     error_count = 0;
  int     cycle_count = 0;
  int     go_count    = 0;
  logic   done_seen   = 1'b0;

  // Reference model of the parameter words and interrupt registers.
  logic [kernel_pkg::data_width-1:0] param_model [kernel_pkg::param_words];
  logic                              gie_m;
  logic [kernel_pkg::irq_width-1:0]  ier_m;
  logic [kernel_pkg::irq_width-1:0]  isr_m;

  // 10 ns clock period.
  always #5 ap_clk = ~ap_clk;

  kernel_wrapper kernel_wrapper_inst (
    .ap_clk(ap_clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .interrupt(interrupt),
    .go_ready(go_ready), .action_rst_n(action_rst_n), .go_stop(go_stop),
    .done_ready(done_ready), .done_stop(done_stop),
    .param_addr_valid(param_addr_valid), .param_addr(param_addr),
    .param_addr_stop(param_addr_stop), .param_data_valid(param_data_valid),
    .param_data(param_data), .param_data_stop(param_data_stop)
  );

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic logic [kernel_pkg::addr_width-1:0] param_addr_of(
    input logic [kernel_pkg::param_index_width-1:0] idx
  );
    return kernel_pkg::ctrl_region_end +
           {{(kernel_pkg::addr_width - kernel_pkg::param_index_width - 2){1'b0}}, idx, 2'b00};
  endfunction

  function automatic logic expected_irq();
    return gie_m && (|(isr_m & ier_m));
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    check_count = check_count + 1;
    if (got !== expected) begin
      error_count = error_count + 1;
      $display("Mismatch at %0t: %s, got %08h, expected %08h", $time, what, got, expected);
    end
  endtask

  // Host write with a randomly stalled B channel.
  task automatic axi_write(input logic [kernel_pkg::addr_width-1:0] addr,
                           input logic [31:0] data, input logic [3:0] strb);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    do begin
      @(posedge ap_clk);
    end while (!awready);
    check_value(32'(wready), 32'h1, "wready together with awready");
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do begin
      bready <= rand_bit();
      @(posedge ap_clk);
    end while (!(bvalid && bready));
    check_value(32'(bresp), 32'(kernel_pkg::resp_okay), "write response code");
    bready <= 1'b0;
  endtask

  // Host read with a randomly stalled R channel.
  task automatic axi_read(input logic [kernel_pkg::addr_width-1:0] addr,
                          output logic [31:0] data);
    araddr  <= addr;
    arvalid <= 1'b1;
    do begin
      @(posedge ap_clk);
    end while (!arready);
    arvalid <= 1'b0;
    do begin
      rready <= rand_bit();
      @(posedge ap_clk);
    end while (!(rvalid && rready));
    data = rdata;
    check_value(32'(rresp), 32'(kernel_pkg::resp_okay), "read response code");
    rready <= 1'b0;
  endtask

  task automatic param_write(input logic [kernel_pkg::param_index_width-1:0] idx,
                             input logic [31:0] data, input logic [3:0] strb);
    axi_write(param_addr_of(idx), data, strb);
    for (int b = 0; b < kernel_pkg::strb_width; b++) begin
      if (strb[b]) begin
        param_model[idx][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  // One action read over the parameter channel, with random data stops.
  task automatic fetch_param(input logic [kernel_pkg::param_index_width-1:0] idx);
    param_addr_valid <= 1'b1;
    param_addr       <= idx;
    do begin
      @(posedge ap_clk);
    end while (param_addr_stop);
    param_addr_valid <= 1'b0;
    do begin
      param_data_stop <= rand_bit();
      @(posedge ap_clk);
    end while (!(param_data_valid && !param_data_stop));
    check_value(param_data, param_model[idx], "parameter channel word");
  endtask

  // Action block: take go, read all parameters, work a while, then report done.
  task automatic run_action();
    logic [31:0] r;
    do begin
      go_stop <= rand_bit();
      @(posedge ap_clk);
    end while (!(go_ready && !go_stop));
    go_stop <= 1'b1;
    for (int i = 0; i < kernel_pkg::param_words; i++) begin
      fetch_param(kernel_pkg::param_index_width'(i));
    end
    r = rand_word();
    repeat (8 + 32'(r[3:0])) @(posedge ap_clk);
    done_ready <= 1'b1;
    do begin
      @(posedge ap_clk);
    end while (done_stop);
    done_ready <= 1'b0;
    done_seen = 1'b1;
  endtask

  // Go transfers are counted and must only happen with the action out of reset.
  always @(posedge ap_clk) begin
    if (rst_n && go_ready && !go_stop) begin
      go_count = go_count + 1;
      check_value(32'(action_rst_n), 32'h1, "action out of reset at go transfer");
    end
  end

  always @(posedge ap_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    kernel_pkg::ctrl_word_t                   rd_word;
    logic [31:0]                              r;
    logic [31:0]                              data;
    logic [31:0]                              got;
    logic [kernel_pkg::param_index_width-1:0] idx;

    rst_n            = 1'b0;
    awaddr           = '0;
    awvalid          = 1'b0;
    wdata            = '0;
    wstrb            = '0;
    wvalid           = 1'b0;
    bready           = 1'b0;
    araddr           = '0;
    arvalid          = 1'b0;
    rready           = 1'b0;
    go_stop          = 1'b1;
    done_ready       = 1'b0;
    param_addr_valid = 1'b0;
    param_addr       = '0;
    param_data_stop  = 1'b0;
    gie_m            = 1'b0;
    ier_m            = '0;
    isr_m            = '0;

    repeat (16) @(posedge ap_clk);
    rst_n <= 1'b1;
    @(posedge ap_clk);
    check_value(32'({awready, wready, bvalid, arready, rvalid, go_ready, action_rst_n,
                     param_data_valid, interrupt}), 32'h0, "outputs after reset");
    axi_read(kernel_pkg::ctrl_off, got);
    rd_word.raw = got;
    check_value(32'(rd_word.field.ap_idle), 32'h1, "ap_idle after reset");

    // Fill every parameter word, then merge random strobed writes over it.
    for (int i = 0; i < kernel_pkg::param_words; i++) begin
      param_write(kernel_pkg::param_index_width'(i), rand_word(), 4'hF);
    end
    for (int n = 0; n < rand_writes; n++) begin
      r = rand_word();
      param_write(r[3:0], rand_word(), r[7:4]);
    end
    for (int i = 0; i < kernel_pkg::param_words; i++) begin
      idx = kernel_pkg::param_index_width'(i);
      axi_read(param_addr_of(idx), got);
      check_value(got, param_model[idx], "parameter read-back");
    end

    // Unmapped space reads as zero and ignores writes.
    axi_write(12'hFFC, rand_word(), 4'hF);
    axi_read(12'hFFC, got);
    check_value(got, 32'h0, "unmapped write then read");
    axi_read(12'h020, got);
    check_value(got, 32'h0, "unused control offset");
    for (int n = 0; n < unmapped_reads; n++) begin
      r = rand_word();
      axi_read({1'b1, r[8:0], 2'b00}, got);
      check_value(got, 32'h0, "unmapped read");
    end

    data = rand_word();
    axi_write(kernel_pkg::gie_off, data, 4'hF);
    gie_m = data[0];
    axi_read(kernel_pkg::gie_off, got);
    check_value(got, 32'(gie_m), "GIE read-back");
    data = rand_word();
    axi_write(kernel_pkg::ier_off, data, 4'hF);
    ier_m = data[kernel_pkg::irq_width-1:0];
    axi_read(kernel_pkg::ier_off, got);
    check_value(got, 32'(ier_m), "IER read-back");
    repeat (2) begin
      axi_write(kernel_pkg::isr_off, 32'h1, 4'hF);
      isr_m[0] = !isr_m[0];
      axi_read(kernel_pkg::isr_off, got);
      check_value(got, 32'(isr_m), "ISR toggle");
    end

    // Only the done source is enabled for the run.
    axi_write(kernel_pkg::gie_off, 32'h1, 4'hF);
    gie_m = 1'b1;
    axi_write(kernel_pkg::ier_off, 32'h1, 4'hF);
    ier_m = kernel_pkg::irq_width'(1);

    fork
      begin
        axi_write(kernel_pkg::ctrl_off, 32'h1, 4'hF);
        wait (go_count == 1);
        isr_m[1] = 1'b1;
        axi_read(kernel_pkg::ctrl_off, got);
        rd_word.raw = got;
        check_value(32'(rd_word.field.ap_idle), 32'h0, "ap_idle during run");
        wait (done_seen);
        isr_m[0] = 1'b1;
        repeat (settle_cycles) @(posedge ap_clk);
        check_value(32'(interrupt), 32'(expected_irq()), "interrupt after done");
      end
      begin
        run_action();
      end
    join

    axi_read(kernel_pkg::ctrl_off, got);
    rd_word.raw = got;
    check_value(32'(rd_word.field.ap_done), 32'h1, "ap_done after run");
    check_value(32'(rd_word.field.ap_idle), 32'h1, "ap_idle after run");
    axi_read(kernel_pkg::ctrl_off, got);
    rd_word.raw = got;
    check_value(32'(rd_word.field.ap_done), 32'h0, "ap_done cleared by read");
    check_value(32'(action_rst_n), 32'h0, "action back in reset");
    check_value(32'(go_count), 32'h1, "go transfers per start");

    axi_read(kernel_pkg::isr_off, got);
    check_value(got, 32'(isr_m), "ISR after run");
    axi_write(kernel_pkg::isr_off, 32'h1, 4'hF);
    isr_m[0] = 1'b0;
    repeat (settle_cycles) @(posedge ap_clk);
    check_value(32'(interrupt), 32'(expected_irq()), "interrupt after ISR clear");

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
